// File: design/rob_settings.svh
`ifndef ROB_SETTINGS_SVH
`define ROB_SETTINGS_SVH

// Lanes in one dispatch group.
`define ROB_DISP_SIZE 2

// Entries in the buffer, one group per entry.
`define ROB_CMT_BLK_SIZE 8

// Done-report ports from the execution units.
`define ROB_CMT_BUS_SIZE 2

// Physical register id width.
`define ROB_RNID_W 6

// Program counter width.
`define ROB_PC_W 32

// Commit id width, log2 of the entry count.
`define ROB_CMT_ID_W 3

// Occupancy counter width, wide enough to hold the full count.
`define ROB_CNT_W (`ROB_CMT_ID_W + 1)

`endif

// File: design/rob_pkg.sv
`include "rob_settings.svh"

package rob_pkg;

  // Commit id, equal to the entry index in the buffer.
  typedef logic [`ROB_CMT_ID_W-1:0] cmt_id_t;

  // Lane mask, one bit per dispatch lane.
  typedef logic [`ROB_DISP_SIZE-1:0] grp_id_t;

  // Physical register id.
  typedef logic [`ROB_RNID_W-1:0] rnid_t;

  // Program counter.
  typedef logic [`ROB_PC_W-1:0] pc_t;

  // One dispatch group as written into an entry.
  typedef struct packed {
    logic                            valid;
    pc_t                             pc_addr;
    grp_id_t                         grp_id;
    grp_id_t                         old_rd_valid;
    rnid_t [`ROB_DISP_SIZE-1:0]      old_rd_rnid;
  } disp_grp_t;

  // One completion report, grp_id holds a single lane.
  typedef struct packed {
    logic                            valid;
    cmt_id_t                         cmt_id;
    grp_id_t                         grp_id;
  } done_rpt_t;

  // Commit block presented for one cycle when the head is done.
  typedef struct packed {
    logic                            commit;
    cmt_id_t                         cmt_id;
    grp_id_t                         grp_id;
    pc_t                             pc_addr;
    grp_id_t                         free_valid;
    rnid_t [`ROB_DISP_SIZE-1:0]      free_rnid;
  } commit_blk_t;

endpackage

// File: design/rob_alloc_ptr.sv
`timescale 1ns/1ns
`include "rob_settings.svh"

module rob_alloc_ptr (
  input  logic             i_clk,
  input  logic             i_rst,

  input  logic             i_in_vld,
  input  logic             i_out_vld,

  output rob_pkg::cmt_id_t o_in_ptr,
  output rob_pkg::cmt_id_t o_out_ptr,
  output logic             o_full
);

  rob_pkg::cmt_id_t        r_in_ptr;
  rob_pkg::cmt_id_t        r_out_ptr;
  logic [`ROB_CNT_W-1:0]   r_count;
  logic                    w_empty;

  // Wrap at the last entry, so the entry count need not be a power of two.
  function automatic rob_pkg::cmt_id_t ptr_inc(input rob_pkg::cmt_id_t ptr);
    if (ptr == rob_pkg::cmt_id_t'(`ROB_CMT_BLK_SIZE - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      r_in_ptr  <= '0;
      r_out_ptr <= '0;
      r_count   <= '0;
    end else begin
      if (i_in_vld) begin
        r_in_ptr <= ptr_inc(r_in_ptr);
      end
      if (i_out_vld) begin
        r_out_ptr <= ptr_inc(r_out_ptr);
      end
      // Dispatch and retire in one cycle leave the count unchanged.
      case ({i_in_vld, i_out_vld})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;
      endcase
    end
  end

  assign w_empty   = (r_count == '0);
  assign o_full    = (r_count == `ROB_CNT_W'(`ROB_CMT_BLK_SIZE));
  assign o_in_ptr  = r_in_ptr;
  assign o_out_ptr = r_out_ptr;

  // The dispatcher has to hold off while every entry is taken.
  a_no_disp_when_full : assert property (@(posedge i_clk) disable iff (i_rst)
    o_full |-> !i_in_vld);

  // Retire comes only from an occupied head entry.
  a_no_retire_when_empty : assert property (@(posedge i_clk) disable iff (i_rst)
    w_empty |-> !i_out_vld);

endmodule

// File: design/rob_entry.sv
`timescale 1ns/1ns
`include "rob_settings.svh"

module rob_entry (
  input  logic                 i_clk,
  input  logic                 i_rst,

  // Index of this entry in the buffer.
  input  rob_pkg::cmt_id_t     i_cmt_id,

  input  logic                 i_load_valid,
  input  rob_pkg::disp_grp_t   i_load,

  input  rob_pkg::done_rpt_t   i_done_rpt [`ROB_CMT_BUS_SIZE],

  input  logic                 i_retire,

  output logic                 o_all_done,
  output rob_pkg::disp_grp_t   o_state
);

  logic                        r_valid;
  rob_pkg::grp_id_t            r_done;
  rob_pkg::disp_grp_t          r_grp;
  rob_pkg::grp_id_t            w_done_set;
  logic                        w_rpt_hit [`ROB_CMT_BUS_SIZE];

  // Match each report port against this entry.
  generate
    for (genvar p_idx = 0; p_idx < `ROB_CMT_BUS_SIZE; p_idx++) begin : rpt_loop
      assign w_rpt_hit[p_idx] = i_done_rpt[p_idx].valid &
                                (i_done_rpt[p_idx].cmt_id == i_cmt_id);

      // A completion must name a lane that was dispatched in this group.
      a_rpt_lane_in_grp : assert property (@(posedge i_clk) disable iff (i_rst)
        (r_valid && w_rpt_hit[p_idx]) |->
        ((i_done_rpt[p_idx].grp_id & ~r_grp.grp_id) == '0));
    end
  endgenerate

  // Lanes reported done this cycle over all ports.
  always_comb begin
    w_done_set = '0;
    for (int p = 0; p < `ROB_CMT_BUS_SIZE; p++) begin
      if (w_rpt_hit[p]) begin
        w_done_set = w_done_set | i_done_rpt[p].grp_id;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      r_valid <= 1'b0;
      r_done  <= '0;
    end else if (i_load_valid) begin
      r_valid <= 1'b1;
      r_done  <= '0;
    end else if (i_retire) begin
      r_valid <= 1'b0;
      r_done  <= '0;
    end else if (r_valid) begin
      r_done  <= r_done | w_done_set;
    end
  end

  // Group payload, only meaningful while r_valid is set.
  always_ff @(posedge i_clk) begin
    if (i_load_valid) begin
      r_grp <= i_load;
    end
  end

  // Done once every dispatched lane has reported.
  assign o_all_done = r_valid & ((r_done & r_grp.grp_id) == r_grp.grp_id);

  always_comb begin
    o_state       = r_grp;
    o_state.valid = r_valid;
  end

  // The tail never reaches an occupied entry.
  a_no_load_when_valid : assert property (@(posedge i_clk) disable iff (i_rst)
    i_load_valid |-> !r_valid);

endmodule

// File: design/rob_commit_sel.sv
`timescale 1ns/1ns
`include "rob_settings.svh"

module rob_commit_sel (
  // Current head pointer.
  input  rob_pkg::cmt_id_t              i_head,

  input  logic [`ROB_CMT_BLK_SIZE-1:0]  i_all_done,
  input  rob_pkg::disp_grp_t            i_state [`ROB_CMT_BLK_SIZE],

  output logic                          o_retire_vld,
  output logic [`ROB_CMT_BLK_SIZE-1:0]  o_retire,

  output rob_pkg::commit_blk_t          o_commit
);

  rob_pkg::disp_grp_t                   w_head_state;
  logic                                 w_head_done;

  // Head entry view.
  assign w_head_state = i_state[i_head];
  assign w_head_done  = i_all_done[i_head];

  // Commit and retire follow the head directly, no register in between.
  assign o_retire_vld = w_head_done;

  always_comb begin
    o_retire = '0;
    for (int e = 0; e < `ROB_CMT_BLK_SIZE; e++) begin
      if (w_head_done && (i_head == rob_pkg::cmt_id_t'(e))) begin
        o_retire[e] = 1'b1;
      end
    end
  end

  // Build the commit block.
  always_comb begin
    o_commit            = '0;
    o_commit.commit     = w_head_done;
    o_commit.cmt_id     = i_head;
    o_commit.grp_id     = w_head_state.grp_id;
    o_commit.pc_addr    = w_head_state.pc_addr;
    // Only lanes in the group that overwrote a register may free one.
    o_commit.free_valid = w_head_state.old_rd_valid & w_head_state.grp_id;
    o_commit.free_rnid  = w_head_state.old_rd_rnid;
  end

endmodule

// File: design/rob_top.sv
`timescale 1ns/1ns
`include "rob_settings.svh"

module rob_top (
  input  logic                  i_clk,
  input  logic                  i_rst,

  // Dispatch side.
  input  rob_pkg::disp_grp_t    i_disp,
  output rob_pkg::cmt_id_t      o_new_cmt_id,
  output logic                  o_full,

  // Completion reports from the execution units.
  input  rob_pkg::done_rpt_t    i_done_rpt [`ROB_CMT_BUS_SIZE],

  // Commit to the rename and free-list logic.
  output rob_pkg::commit_blk_t  o_commit
);

  rob_pkg::cmt_id_t             w_in_ptr;
  rob_pkg::cmt_id_t             w_out_ptr;
  logic                         w_retire_vld;
  logic [`ROB_CMT_BLK_SIZE-1:0] w_retire;
  logic [`ROB_CMT_BLK_SIZE-1:0] w_all_done;
  rob_pkg::disp_grp_t           w_state [`ROB_CMT_BLK_SIZE];

  rob_alloc_ptr u_ptr (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_in_vld  (i_disp.valid),
    .i_out_vld (w_retire_vld),
    .o_in_ptr  (w_in_ptr),
    .o_out_ptr (w_out_ptr),
    .o_full    (o_full)
  );

  generate
    for (genvar c_idx = 0; c_idx < `ROB_CMT_BLK_SIZE; c_idx++) begin : entry_loop
      localparam rob_pkg::cmt_id_t entry_id = rob_pkg::cmt_id_t'(c_idx);

      logic w_load_valid;

      // Only the entry at the tail takes the group.
      assign w_load_valid = i_disp.valid & (w_in_ptr == entry_id);

      rob_entry u_entry (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_cmt_id     (entry_id),
        .i_load_valid (w_load_valid),
        .i_load       (i_disp),
        .i_done_rpt   (i_done_rpt),
        .i_retire     (w_retire[c_idx]),
        .o_all_done   (w_all_done[c_idx]),
        .o_state      (w_state[c_idx])
      );
    end
  endgenerate

  rob_commit_sel u_commit_sel (
    .i_head       (w_out_ptr),
    .i_all_done   (w_all_done),
    .i_state      (w_state),
    .o_retire_vld (w_retire_vld),
    .o_retire     (w_retire),
    .o_commit     (o_commit)
  );

  assign o_new_cmt_id = w_in_ptr;

  // A commit always carries at least one lane.
  a_commit_has_lane : assert property (@(posedge i_clk) disable iff (i_rst)
    o_commit.commit |-> (o_commit.grp_id != '0));

endmodule

// File: verif/rob_tb.sv
`timescale 1ns/1ns
`include "rob_settings.svh"

module rob_tb;

  logic                  i_clk;
  logic                  i_rst;
  rob_pkg::disp_grp_t    i_disp;
  rob_pkg::done_rpt_t    i_done_rpt [`ROB_CMT_BUS_SIZE];
  rob_pkg::cmt_id_t      o_new_cmt_id;
  logic                  o_full;
  rob_pkg::commit_blk_t  o_commit;

  // Reference model, one stored group per expected commit id.
  rob_pkg::disp_grp_t    model_grp [`ROB_CMT_BLK_SIZE];
  rob_pkg::commit_blk_t  seen_q [$];
  int                    n_disp;
  int                    n_cmt;
  integer                seed = 32'h73938c5c;

  rob_top DUT (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_disp       (i_disp),
    .o_new_cmt_id (o_new_cmt_id),
    .o_full       (o_full),
    .i_done_rpt   (i_done_rpt),
    .o_commit     (o_commit)
  );

  always #10 i_clk = ~i_clk;

  // Commit pulses are collected at the rising edge, before the retire takes effect.
  always @(posedge i_clk) begin
    if (!i_rst && o_commit.commit) begin
      seen_q.push_back(o_commit);
    end
  end

  task automatic stop_run();
    $display("ERRORS FOUND");
    $fatal(1, "Stopped at the first error.");
  endtask

  task automatic check_value(input string name, input logic [63:0] exp_val,
                             input logic [63:0] got_val);
    assert (got_val === exp_val) else begin
      $display("ERROR: time %0t, %s expected %0h got %0h", $time, name, exp_val, got_val);
      stop_run();
    end
  endtask

  function automatic rob_pkg::cmt_id_t id_of(input int n);
    return rob_pkg::cmt_id_t'(n % `ROB_CMT_BLK_SIZE);
  endfunction

  function automatic rob_pkg::grp_id_t rand_lanes();
    rob_pkg::grp_id_t lanes;
    lanes = rob_pkg::grp_id_t'($random(seed));
    if (lanes == '0) begin
      lanes = '1;
    end
    return lanes;
  endfunction

  task automatic dispatch_group(input rob_pkg::grp_id_t lanes, input rob_pkg::grp_id_t old_rd);
    rob_pkg::disp_grp_t g;
    g = '0;
    check_value("o_new_cmt_id", id_of(n_disp), o_new_cmt_id);
    check_value("o_full", 0, o_full);
    g.valid        = 1'b1;
    g.pc_addr      = rob_pkg::pc_t'($random(seed)) & ~32'h3;
    g.grp_id       = lanes;
    g.old_rd_valid = old_rd;
    for (int l = 0; l < `ROB_DISP_SIZE; l++) begin
      g.old_rd_rnid[l] = rob_pkg::rnid_t'($random(seed));
    end
    model_grp[id_of(n_disp)] = g;
    i_disp = g;
    @(negedge i_clk);
    i_disp = '0;
    n_disp = n_disp + 1;
    check_value("o_new_cmt_id", id_of(n_disp), o_new_cmt_id);
    check_value("o_full", (n_disp - n_cmt) == `ROB_CMT_BLK_SIZE, o_full);
  endtask

  // Port p carries lane p, so a full group completes in one cycle.
  task automatic report_done(input rob_pkg::cmt_id_t id, input rob_pkg::grp_id_t lanes);
    for (int p = 0; p < `ROB_CMT_BUS_SIZE; p++) begin
      i_done_rpt[p].valid  = lanes[p];
      i_done_rpt[p].cmt_id = id;
      i_done_rpt[p].grp_id = rob_pkg::grp_id_t'(1 << p);
    end
    @(negedge i_clk);
    for (int p = 0; p < `ROB_CMT_BUS_SIZE; p++) begin
      i_done_rpt[p] = '0;
    end
  endtask

  task automatic expect_commit();
    rob_pkg::commit_blk_t got;
    rob_pkg::disp_grp_t   g;
    int                   waited;
    waited = 0;
    g = model_grp[id_of(n_cmt)];
    while (seen_q.size() == 0 && waited < 20) begin
      @(negedge i_clk);
      waited = waited + 1;
    end
    assert (seen_q.size() != 0) else begin
      $display("Commit of id %0d did not arrive within 20 cycles", id_of(n_cmt));
      stop_run();
    end
    got = seen_q.pop_front();
    check_value("o_commit.cmt_id", id_of(n_cmt), got.cmt_id);
    check_value("o_commit.grp_id", g.grp_id, got.grp_id);
    check_value("o_commit.pc_addr", g.pc_addr, got.pc_addr);
    check_value("o_commit.free_valid", g.old_rd_valid & g.grp_id, got.free_valid);
    check_value("o_commit.free_rnid", g.old_rd_rnid, got.free_rnid);
    n_cmt = n_cmt + 1;
  endtask

  task automatic check_idle(input int cycles);
    repeat (cycles) begin
      @(negedge i_clk);
      assert (seen_q.size() == 0) else begin
        $display("Unexpected commit of id %0d", seen_q[0].cmt_id);
        stop_run();
      end
      check_value("o_commit.commit", 0, o_commit.commit);
    end
  endtask

  initial begin
    int base;
    i_clk  = 1'b0;
    i_rst  = 1'b1;
    i_disp = '0;
    n_disp = 0;
    n_cmt  = 0;
    for (int p = 0; p < `ROB_CMT_BUS_SIZE; p++) begin
      i_done_rpt[p] = '0;
    end
    repeat (16) @(negedge i_clk);
    i_rst = 1'b0;

    check_value("o_commit.commit", 0, o_commit.commit);
    check_value("o_full", 0, o_full);
    check_value("o_new_cmt_id", 0, o_new_cmt_id);
    check_idle(2);

    // Two-lane group, both lanes together and then split.
    dispatch_group(2'b11, rand_lanes());
    report_done(id_of(n_cmt), 2'b11);
    expect_commit();
    check_idle(3);
    dispatch_group(2'b11, rand_lanes());
    report_done(id_of(n_cmt), 2'b01);
    check_idle(2);
    report_done(id_of(n_cmt), 2'b10);
    expect_commit();
    check_idle(3);

    // Out-of-order completion, in-order commit.
    base = n_disp;
    for (int i = 0; i < 3; i++) begin
      dispatch_group(rand_lanes(), rand_lanes());
    end
    report_done(id_of(base + 2), model_grp[id_of(base + 2)].grp_id);
    check_idle(3);
    report_done(id_of(base), model_grp[id_of(base)].grp_id);
    expect_commit();
    check_idle(3);
    report_done(id_of(base + 1), model_grp[id_of(base + 1)].grp_id);
    expect_commit();
    expect_commit();
    check_idle(3);

    // Single-lane groups.
    dispatch_group(2'b01, 2'b11);
    report_done(id_of(n_cmt), 2'b01);
    expect_commit();
    dispatch_group(2'b10, 2'b01);
    report_done(id_of(n_cmt), 2'b10);
    expect_commit();
    check_idle(2);

    // Fill the buffer, drain it and wrap the ids.
    for (int i = 0; i < `ROB_CMT_BLK_SIZE; i++) begin
      dispatch_group(rand_lanes(), rand_lanes());
    end
    check_value("o_full", 1, o_full);
    base = n_cmt;
    report_done(id_of(base), model_grp[id_of(base)].grp_id);
    expect_commit();
    check_value("o_full", 0, o_full);
    for (int i = 1; i < `ROB_CMT_BLK_SIZE; i++) begin
      report_done(id_of(base + i), model_grp[id_of(base + i)].grp_id);
    end
    for (int i = 1; i < `ROB_CMT_BLK_SIZE; i++) begin
      expect_commit();
    end
    check_idle(3);
    dispatch_group(rand_lanes(), rand_lanes());
    dispatch_group(rand_lanes(), rand_lanes());

    // Dispatch in the cycle that the head commits.
    report_done(id_of(n_cmt), model_grp[id_of(n_cmt)].grp_id);
    check_value("o_commit.commit", 1, o_commit.commit);
    dispatch_group(rand_lanes(), rand_lanes());
    expect_commit();
    base = n_cmt;
    report_done(id_of(base), model_grp[id_of(base)].grp_id);
    report_done(id_of(base + 1), model_grp[id_of(base + 1)].grp_id);
    expect_commit();
    expect_commit();
    check_idle(3);
    check_value("o_full", 0, o_full);

    $display("NO ERRORS");
    $finish;
  end

endmodule

// File: rob_top.f
+incdir+design
design/rob_pkg.sv
design/rob_alloc_ptr.sv
design/rob_entry.sv
design/rob_commit_sel.sv
design/rob_top.sv
verif/rob_tb.sv
